// ==== Bender.yml ====
package:
  name: bin_dot_flp

export_include_dirs:
  - rtl

sources:
  - files:
      - rtl/bin_dot_pkg.sv
      - rtl/lut_flp.sv
      - rtl/lut_unit_flp.sv
      - rtl/float_add.sv
      - rtl/sum_tree_flp.sv
      - rtl/bin_dot_flp.sv
  - target: test
    files:
      - bench/bin_dot_assert.sv
      - bench/tb_bin_dot_flp.sv

// ==== bench/bin_dot_assert.sv ====
module bin_dot_assert
    import bin_dot_pkg::*;
(
    input logic     clk,
    input logic     arst_n,
    input logic     in_valid,
    input logic     out_valid,
    input float32_t result
);

    timeunit 1ns;
    timeprecision 1ps;

    int n_fails = 0;

    a_reset_quiet: assert property (@(posedge clk) !arst_n |-> !out_valid)
        else begin
            n_fails++;
            $error("out_valid high while arst_n is low");
        end

    // Table stage plus two adder levels.
    a_latency: assert property (@(posedge clk) disable iff (!arst_n)
        out_valid == $past(in_valid, 3))
        else begin
            n_fails++;
            $error("out_valid does not follow in_valid by 3 cycles");
        end

    a_exp_range: assert property (@(posedge clk) disable iff (!arst_n)
        out_valid |-> result.exp != 8'hff)
        else begin
            n_fails++;
            $error("result exponent is 255");
        end

endmodule

// ==== bench/bin_dot_cases.txt ====
# Columns: test name, sel in hex, expected result bits in hex.
# Expected values use truncating float arithmetic with no rounding.
all_zero      0000  c41a091a
all_one       ffff  441a091a
bit0          0001  c419891a
bit6          0040  c412091a
bit8          0100  c41a091a
bit12         1000  c2066670
bit15         8000  c419a91a
zero_5555     5555  00000000
zero_aaaa     aaaa  00000000
mixed_align   7155  44133c4c
mixed_cancel  df5d  3dcce000
mixed_small   5355  40cccd00

// ==== bench/tb_bin_dot_flp.sv ====
`include "bin_dot_params.svh"

module tb_bin_dot_flp
    import bin_dot_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int    TIMEOUT    = 50;
    localparam int    LATENCY    = 3;
    localparam string CASES_FILE = "bench/bin_dot_cases.txt";

    logic                  clk;
    logic                  arst_n;
    logic                  in_valid;
    logic [`SEL_WIDTH-1:0] sel;
    logic                  out_valid;
    float32_t              result;

    string                 case_name [$];
    logic [`SEL_WIDTH-1:0] case_sel  [$];
    float32_t              case_exp  [$];

    // Cases in flight, oldest first.
    string    pend_name [$];
    float32_t pend_exp  [$];
    int       pend_due  [$];

    int cyc = 0;
    int n_tests = 0;
    int n_errors = 0;
    bit timed_out = 1'b0;

    bin_dot_flp u_bin_dot_flp (
        .clk      (clk),
        .arst_n   (arst_n),
        .in_valid (in_valid),
        .sel      (sel),
        .out_valid(out_valid),
        .result   (result)
    );

    bind bin_dot_flp bin_dot_assert u_assert (
        .clk      (clk),
        .arst_n   (arst_n),
        .in_valid (in_valid),
        .out_valid(out_valid),
        .result   (result)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    task automatic load_cases();
        int fd;
        int code;
        string line;
        string name;
        logic [31:0] sel_val;
        logic [31:0] exp_val;
        fd = $fopen(CASES_FILE, "r");
        if (fd == 0) begin
            $display("Could not open %s", CASES_FILE);
            return;
        end
        while (!$feof(fd)) begin
            code = $fgets(line, fd);
            if (code > 0 && line.len() > 1 && line[0] != "#") begin
                code = $sscanf(line, "%s %h %h", name, sel_val, exp_val);
                if (code == 3) begin
                    case_name.push_back(name);
                    case_sel.push_back(sel_val[`SEL_WIDTH-1:0]);
                    case_exp.push_back(float32_t'(exp_val));
                end
            end
        end
        $fclose(fd);
    endtask

    task automatic check_result(input string name, input float32_t expected,
                                input float32_t actual, output bit ok);
        ok = (actual === expected);
        if (!ok) begin
            $display("[ERROR] %s result: expected %h, got %h", name, expected, actual);
            n_errors++;
        end
    endtask

    task automatic check_latency(input string name, input int due, input int actual,
                                 output bit ok);
        ok = (actual == due);
        if (!ok) begin
            $display("%s arrived at edge %0d but was due at edge %0d", name, actual, due);
            n_errors++;
        end
    endtask

    // Output must stay quiet for the given number of cycles.
    task automatic check_idle(input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            if (out_valid !== 1'b0) begin
                $display("out_valid was high at edge %0d with no case in flight", cyc);
                n_errors++;
            end
        end
    endtask

    task automatic wait_out_valid(output bit seen);
        int waited;
        waited = 0;
        @(negedge clk);
        while (out_valid !== 1'b1 && waited < TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        seen = (out_valid === 1'b1);
    endtask

    task automatic drive_cases(input bit with_gaps);
        int gap;
        string tag;
        tag = with_gaps ? "gap" : "b2b";
        for (int i = 0; i < case_sel.size(); i++) begin
            @(negedge clk);
            in_valid = 1'b1;
            sel = case_sel[i];
            pend_name.push_back({tag, ":", case_name[i]});
            pend_exp.push_back(case_exp[i]);
            pend_due.push_back(cyc + 1 + LATENCY); // Taking edge is the next one.
            if (with_gaps) begin
                gap = $urandom_range(3, 0);
                repeat (gap) begin
                    @(negedge clk);
                    in_valid = 1'b0;
                end
            end
        end
        @(negedge clk);
        in_valid = 1'b0;
    endtask

    task automatic collect_results(input int count);
        bit seen;
        bit val_ok;
        bit lat_ok;
        string name;
        float32_t expected;
        int due;
        for (int i = 0; i < count; i++) begin
            wait_out_valid(seen);
            if (!seen) begin
                $display("Timed out after %0d cycles waiting for out_valid", TIMEOUT);
                timed_out = 1'b1;
                return;
            end
            if (pend_exp.size() == 0) begin
                $display("out_valid was high at edge %0d with no case in flight", cyc + 1);
                n_errors++;
                continue;
            end
            name = pend_name.pop_front();
            expected = pend_exp.pop_front();
            due = pend_due.pop_front();
            check_result(name, expected, result, val_ok);
            check_latency(name, due, cyc + 1, lat_ok);
            n_tests++;
            $display("%-20s %s", name, (val_ok && lat_ok) ? "ok" : "error");
        end
    endtask

    initial begin
        void'($urandom(65579));
        arst_n = 1'b0;
        in_valid = 1'b0;
        sel = '0;
        load_cases();

        repeat (3) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;

        check_idle(5); // Nothing before the first case.

        if (case_sel.size() == 0) begin
            $display("No cases were read from %s", CASES_FILE);
            n_errors++;
        end else begin
            // Back to back first, then with random idle gaps.
            fork
                drive_cases(1'b0);
                collect_results(case_sel.size());
            join
            if (!timed_out) begin
                fork
                    drive_cases(1'b1);
                    collect_results(case_sel.size());
                join
            end
            if (!timed_out) begin
                check_idle(10);
            end
        end

        $display("%0d tests checked, %0d errors, %0d assertion failures",
                 n_tests, n_errors, u_bin_dot_flp.u_assert.n_fails);
        if (n_errors == 0 && !timed_out && u_bin_dot_flp.u_assert.n_fails == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== bin_dot_flp.f ====
+incdir+rtl
rtl/bin_dot_pkg.sv
rtl/lut_flp.sv
rtl/lut_unit_flp.sv
rtl/float_add.sv
rtl/sum_tree_flp.sv
rtl/bin_dot_flp.sv
bench/bin_dot_assert.sv
bench/tb_bin_dot_flp.sv

// ==== rtl/bin_dot_flp.sv ====
`include "bin_dot_params.svh"

module bin_dot_flp
    import bin_dot_pkg::*;
(
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  in_valid,
    input  logic [`SEL_WIDTH-1:0] sel,
    output logic                  out_valid,
    output float32_t              result
);

    logic     part_valid;
    float32_t parts [`N_LUTS];

    // Table stage, one cycle.
    lut_unit_flp u_lut_unit (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_valid  (in_valid),
        .sel       (sel),
        .part_valid(part_valid),
        .parts     (parts)
    );

    // Adder tree, two cycles.
    sum_tree_flp u_sum_tree (
        .clk      (clk),
        .arst_n   (arst_n),
        .in_valid (part_valid),
        .parts    (parts),
        .out_valid(out_valid),
        .total    (result)
    );

endmodule

// ==== rtl/bin_dot_params.svh ====
`ifndef BIN_DOT_PARAMS_SVH
`define BIN_DOT_PARAMS_SVH

// Width of the binarized input vector.
`define SEL_WIDTH 16

// Bits per table slice.
`define LUT_SIZE 4

// Number of tables, one per slice.
`define N_LUTS (`SEL_WIDTH / `LUT_SIZE)

// Signed fixed point factors, sign bit on top.
`define N_INT 15
`define N_FRAC 16

`define FIX_WIDTH (`N_INT + `N_FRAC + 1)

`endif

// ==== rtl/bin_dot_pkg.sv ====
`include "bin_dot_params.svh"

package bin_dot_pkg;

    typedef struct packed {
        logic       sign;
        logic [7:0] exp;   // Biased by 127, zero means zero.
        logic [22:0] mant;
    } float32_t;

    typedef logic signed [`FIX_WIDTH-1:0] fixed_t;

    // Factors in Q15.16, pairs of equal values.
    localparam fixed_t FACT [`SEL_WIDTH] = '{
        32'sh0001_0000, 32'sh0001_0000, 32'sh0002_8000, 32'sh0002_8000,
        -32'sh0000_4000, -32'sh0000_4000, 32'sh0010_0000, 32'sh0010_0000,
        32'sh0000_0001, 32'sh0000_0001, -32'sh0003_3333, -32'sh0003_3333,
        32'sh0123_4567, 32'sh0123_4567, 32'sh0000_c000, 32'sh0000_c000
    };

    // Truncating conversion, leading one becomes the hidden bit.
    function automatic float32_t fix_to_float(input fixed_t v);
        logic [`FIX_WIDTH-1:0] mag;
        logic [`FIX_WIDTH-1:0] norm;
        int pos;
        float32_t f;
        f = '0;
        pos = 0;
        mag = v[`FIX_WIDTH-1] ? -v : v;
        if (mag == 0) begin
            return f;
        end
        for (int i = 0; i < `FIX_WIDTH; i++) begin
            if (mag[i]) pos = i;
        end
        norm = mag << (`FIX_WIDTH - 1 - pos);
        f.sign = v[`FIX_WIDTH-1];
        f.exp = 8'(pos + 127 - `N_FRAC);
        f.mant = norm[`FIX_WIDTH-2 -: 23];
        return f;
    endfunction

    // Signed sum of one slice, bit set adds the factor, bit clear subtracts it.
    function automatic fixed_t slice_sum(input int offset, input int idx);
        fixed_t acc;
        acc = '0;
        for (int i = 0; i < `LUT_SIZE; i++) begin
            if (idx[i]) begin
                acc += FACT[offset + i];
            end else begin
                acc -= FACT[offset + i];
            end
        end
        return acc;
    endfunction

endpackage

// ==== rtl/float_add.sv ====
module float_add
    import bin_dot_pkg::*;
(
    input  logic     clk,
    input  logic     arst_n,
    input  logic     in_valid,
    input  float32_t a,
    input  float32_t b,
    output logic     out_valid,
    output float32_t sum
);

    float32_t op_hi;
    float32_t op_lo;
    logic [23:0] hi_m;
    logic [23:0] lo_m;
    logic [23:0] lo_aligned;
    logic [24:0] raw;
    logic [24:0] norm;
    logic [4:0] lead;
    logic signed [9:0] exp_calc;
    float32_t res;

    always_comb begin
        // Larger magnitude first, so subtraction never goes negative.
        if ({a.exp, a.mant} >= {b.exp, b.mant}) begin
            op_hi = a;
            op_lo = b;
        end else begin
            op_hi = b;
            op_lo = a;
        end

        hi_m = (op_hi.exp != 8'd0) ? {1'b1, op_hi.mant} : 24'd0;
        lo_m = (op_lo.exp != 8'd0) ? {1'b1, op_lo.mant} : 24'd0;
        lo_aligned = lo_m >> (op_hi.exp - op_lo.exp); // Shifted-out bits dropped.

        if (op_hi.sign == op_lo.sign) begin
            raw = {1'b0, hi_m} + {1'b0, lo_aligned};
        end else begin
            raw = {1'b0, hi_m} - {1'b0, lo_aligned};
        end

        lead = 5'd0;
        for (int i = 0; i < 25; i++) begin
            if (raw[i]) lead = 5'(i);
        end

        // Leading one to bit 24, covers the carry case too.
        norm = raw << (5'd24 - lead);
        exp_calc = $signed({2'b00, op_hi.exp}) + $signed({5'b00000, lead}) - 10'sd23;

        res = '0;
        if (raw != 25'd0 && exp_calc > 10'sd0) begin
            res.sign = op_hi.sign;
            res.exp = exp_calc[7:0];
            res.mant = norm[23:1];
        end
    end

    always_ff @(posedge clk) begin
        sum <= res;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= in_valid;
        end
    end

endmodule

// ==== rtl/lut_flp.sv ====
`include "bin_dot_params.svh"

module lut_flp
    import bin_dot_pkg::*;
#(
    parameter int offset = 0
) (
    input  logic [`LUT_SIZE-1:0] sel,
    output float32_t             entry
);

    float32_t mem [2**`LUT_SIZE];

    // Table contents are fixed at elaboration.
    generate
        for (genvar i = 0; i < 2**`LUT_SIZE; i++) begin : g_entry
            localparam float32_t VAL = fix_to_float(slice_sum(offset, i));

            assign mem[i] = VAL;
        end
    endgenerate

    assign entry = mem[sel]; // Plain combinational read.

endmodule

// ==== rtl/lut_unit_flp.sv ====
`include "bin_dot_params.svh"

module lut_unit_flp
    import bin_dot_pkg::*;
(
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  in_valid,
    input  logic [`SEL_WIDTH-1:0] sel,
    output logic                  part_valid,
    output float32_t              parts [`N_LUTS]
);

    float32_t entries [`N_LUTS];

    // One table per slice, each with its own factor offset.
    generate
        for (genvar i = 0; i < `N_LUTS; i++) begin : g_lut
            lut_flp #(
                .offset(i * `LUT_SIZE)
            ) u_lut (
                .sel  (sel[i*`LUT_SIZE +: `LUT_SIZE]),
                .entry(entries[i])
            );
        end
    endgenerate

    always_ff @(posedge clk) begin
        parts <= entries;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            part_valid <= 1'b0;
        end else begin
            part_valid <= in_valid; // One stage, same as parts.
        end
    end

endmodule

// ==== rtl/sum_tree_flp.sv ====
`include "bin_dot_params.svh"

module sum_tree_flp
    import bin_dot_pkg::*;
(
    input  logic     clk,
    input  logic     arst_n,
    input  logic     in_valid,
    input  float32_t parts [`N_LUTS],
    output logic     out_valid,
    output float32_t total
);

    localparam int N_NODES = 2 * `N_LUTS - 1;

    // Heap order. Node k reads children 2k+1 and 2k+2, leaves sit at the end.
    float32_t node     [N_NODES];
    logic     node_vld [N_NODES];

    generate
        for (genvar i = 0; i < `N_LUTS; i++) begin : g_leaf
            assign node[`N_LUTS - 1 + i]     = parts[i];
            assign node_vld[`N_LUTS - 1 + i] = in_valid;
        end

        // Two adders on level one, one on level two.
        for (genvar k = 0; k < `N_LUTS - 1; k++) begin : g_add
            float_add u_add (
                .clk      (clk),
                .arst_n   (arst_n),
                .in_valid (node_vld[2*k + 1] & node_vld[2*k + 2]),
                .a        (node[2*k + 1]),
                .b        (node[2*k + 2]),
                .out_valid(node_vld[k]),
                .sum      (node[k])
            );
        end
    endgenerate

    assign total     = node[0];
    assign out_valid = node_vld[0]; // Root is the last adder.

endmodule
